/* logic/yuv_rgb_config.svh */
`ifndef YUV_RGB_CONFIG_SVH
`define YUV_RGB_CONFIG_SVH

// image size in pixels, width a multiple of eight
`define IMG_WIDTH 16
`define IMG_HEIGHT 2

// memory map in 16-bit words
`define Y_BASE 0
`define U_BASE (`Y_BASE + `IMG_WIDTH * `IMG_HEIGHT / 2)
`define V_BASE (`U_BASE + `IMG_WIDTH * `IMG_HEIGHT / 4)
`define RGB_BASE (`V_BASE + `IMG_WIDTH * `IMG_HEIGHT / 4)

// sram bus
`define SRAM_LATENCY 2
`define SRAM_ADDR_W 18

// six-tap chroma interpolation
`define FIR_C0 21
`define FIR_C1 (-52)
`define FIR_C2 159
`define FIR_ROUND 128
`define FIR_SHIFT 8

// yuv to rgb matrix in 16-bit fixed point
`define CSC_KY 76284
`define CSC_KRV 104595
`define CSC_KGU (-25624)
`define CSC_KGV (-53281)
`define CSC_KBU 132251
`define CSC_SHIFT 16
`define Y_OFFSET 16
`define C_OFFSET 128

`endif

/* logic/yuv_rgb_pkg.sv */
`default_nettype none
`include "yuv_rgb_config.svh"

package yuv_rgb_pkg;

	typedef logic [`SRAM_ADDR_W-1:0] sram_addr_t;
	// two samples per word, high byte first
	typedef logic [15:0] sram_word_t;
	typedef logic [7:0] pixel_t;
	// filtered chroma can overshoot 0..255 on either side
	typedef logic signed [15:0] chroma_t;
	typedef logic signed [31:0] product_t;

	typedef enum logic [2:0] {
		idle,
		lead_in,
		pair_read,
		pair_write,
		lead_out,
		frame_done
	} seq_state_t;

endpackage

`default_nettype wire

/* logic/chroma_upsampler.sv */
`timescale 1ns/1ps
`default_nettype none
`include "yuv_rgb_config.svh"

module chroma_upsampler import yuv_rgb_pkg::*; (
	input  logic       CLOCK_50_I,
	input  logic       Resetn,
	input  sram_word_t read_data,
	input  logic       chroma_capture,
	input  logic       row_start,
	input  logic       shift,
	output pixel_t     even_chroma,
	output chroma_t    odd_chroma
);

	localparam int SAMPLES = `IMG_WIDTH / 2;
	localparam int IDX_W = $clog2(SAMPLES + 1);
	localparam logic [IDX_W-1:0] ROW_SAMPLES = IDX_W'(SAMPLES);
	// samples 0..3 arrive with the row start fill
	localparam logic [IDX_W-1:0] FIRST_FETCH = IDX_W'(4);

	// window holds C[k-2] .. C[k+3] for pair k
	pixel_t window [6];
	sram_word_t held_word;
	logic low_byte;
	logic [1:0] fill_left;
	logic [IDX_W-1:0] next_idx;
	pixel_t next_sample;
	product_t tap_outer;
	product_t tap_mid;
	product_t tap_inner;
	product_t fir_sum;

	assign next_sample = low_byte ? held_word[7:0] : held_word[15:8];

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			fill_left <= 2'd0;
			low_byte <= 1'b0;
			next_idx <= '0;
		end else if (row_start) begin
			fill_left <= 2'd2;
			low_byte <= 1'b0;
			next_idx <= FIRST_FETCH;
		end else begin
			if (chroma_capture && fill_left != 2'd0)
				fill_left <= fill_left - 1'b1;
			if (shift && next_idx < ROW_SAMPLES) begin
				low_byte <= !low_byte;
				next_idx <= next_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (chroma_capture) begin
			case (fill_left)
				// first word, left edge replicated
				2'd2: begin
					window[0] <= read_data[15:8];
					window[1] <= read_data[15:8];
					window[2] <= read_data[15:8];
					window[3] <= read_data[7:0];
				end
				2'd1: begin
					window[4] <= read_data[15:8];
					window[5] <= read_data[7:0];
				end
				default: held_word <= read_data;
			endcase
		end
		if (shift) begin
			for (int i = 0; i < 5; i++)
				window[i] <= window[i+1];
			// past the row end the last sample repeats
			window[5] <= (next_idx < ROW_SAMPLES) ? next_sample : window[5];
		end
	end

	assign tap_outer = product_t'(window[0]) + product_t'(window[5]);
	assign tap_mid = product_t'(window[1]) + product_t'(window[4]);
	assign tap_inner = product_t'(window[2]) + product_t'(window[3]);
	assign fir_sum = `FIR_C0 * tap_outer + `FIR_C1 * tap_mid + `FIR_C2 * tap_inner + `FIR_ROUND;

	assign even_chroma = window[2];
	assign odd_chroma = chroma_t'(fir_sum >>> `FIR_SHIFT);

endmodule

`default_nettype wire

/* logic/color_matrix.sv */
`timescale 1ns/1ps
`default_nettype none
`include "yuv_rgb_config.svh"

module color_matrix import yuv_rgb_pkg::*; (
	input  logic       CLOCK_50_I,
	input  logic       Resetn,
	input  sram_word_t y_word,
	input  logic       y_capture,
	input  logic       pair_go,
	input  pixel_t     u_even,
	input  pixel_t     v_even,
	input  chroma_t    u_odd,
	input  chroma_t    v_odd,
	output logic       rgb_valid,
	output pixel_t     r0,
	output pixel_t     g0,
	output pixel_t     b0,
	output pixel_t     r1,
	output pixel_t     g1,
	output pixel_t     b1
);

	sram_word_t y_pair;
	// index 0 is the even pixel, index 1 the odd one
	product_t y_off [2];
	product_t u_off [2];
	product_t v_off [2];
	product_t y_term [2];
	product_t rv_term [2];
	product_t gu_term [2];
	product_t gv_term [2];
	product_t bu_term [2];
	logic stage1_valid;
	pixel_t r_q [2];
	pixel_t g_q [2];
	pixel_t b_q [2];

	function automatic pixel_t saturate(input product_t sum);
		product_t scaled;
		scaled = sum >>> `CSC_SHIFT;
		if (scaled < 0)
			return 8'd0;
		else if (scaled > 255)
			return 8'd255;
		else
			return scaled[7:0];
	endfunction

	assign y_off[0] = product_t'(y_pair[15:8]) - `Y_OFFSET;
	assign y_off[1] = product_t'(y_pair[7:0]) - `Y_OFFSET;
	assign u_off[0] = product_t'(u_even) - `C_OFFSET;
	assign v_off[0] = product_t'(v_even) - `C_OFFSET;
	// odd chroma is signed, so the cast sign-extends
	assign u_off[1] = product_t'(u_odd) - `C_OFFSET;
	assign v_off[1] = product_t'(v_odd) - `C_OFFSET;

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			stage1_valid <= 1'b0;
			rgb_valid <= 1'b0;
		end else begin
			stage1_valid <= pair_go;
			rgb_valid <= stage1_valid;
		end
	end

	always_ff @(posedge CLOCK_50_I) begin
		if (y_capture)
			y_pair <= y_word;
		// stage one: one multiplier per term
		if (pair_go) begin
			for (int i = 0; i < 2; i++) begin
				y_term[i] <= `CSC_KY * y_off[i];
				rv_term[i] <= `CSC_KRV * v_off[i];
				gu_term[i] <= `CSC_KGU * u_off[i];
				gv_term[i] <= `CSC_KGV * v_off[i];
				bu_term[i] <= `CSC_KBU * u_off[i];
			end
		end
		// stage two: sum, scale and clip
		if (stage1_valid) begin
			for (int i = 0; i < 2; i++) begin
				r_q[i] <= saturate(y_term[i] + rv_term[i]);
				g_q[i] <= saturate(y_term[i] + gu_term[i] + gv_term[i]);
				b_q[i] <= saturate(y_term[i] + bu_term[i]);
			end
		end
	end

	assign r0 = r_q[0];
	assign g0 = g_q[0];
	assign b0 = b_q[0];
	assign r1 = r_q[1];
	assign g1 = g_q[1];
	assign b1 = b_q[1];

endmodule

`default_nettype wire

/* logic/sram_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none
`include "yuv_rgb_config.svh"

module sram_sequencer import yuv_rgb_pkg::*; (
	input  logic       CLOCK_50_I,
	input  logic       Resetn,
	input  logic       start,
	output sram_addr_t sram_address,
	output logic       sram_we_n,
	output sram_word_t sram_write_data,
	output logic       done,
	output logic [1:0] chroma_capture,
	output logic       row_start,
	output logic       shift,
	output logic       y_capture,
	output logic       pair_go,
	input  logic       rgb_valid,
	input  pixel_t     r0,
	input  pixel_t     g0,
	input  pixel_t     b0,
	input  pixel_t     r1,
	input  pixel_t     g1,
	input  pixel_t     b1
);

	localparam int PAIRS = `IMG_WIDTH / 2;
	localparam int PAIR_W = $clog2(PAIRS + 1);
	localparam int ROW_W = $clog2(`IMG_HEIGHT + 1);
	localparam logic [PAIR_W-1:0] LAST_PAIR = PAIR_W'(PAIRS - 1);
	// two chroma words per row come in during lead-in
	localparam logic [PAIR_W-1:0] CHROMA_PAIRS = PAIR_W'(PAIRS - 4);
	localparam logic [ROW_W-1:0] LAST_ROW = ROW_W'(`IMG_HEIGHT - 1);

	seq_state_t state;
	// six phases per slot, pair_read covers 0..2 and pair_write 3..5
	logic [2:0] phase;
	logic [PAIR_W-1:0] pair_cnt;
	logic [ROW_W-1:0] row_cnt;
	sram_addr_t y_addr;
	sram_addr_t u_addr;
	sram_addr_t v_addr;
	sram_addr_t rgb_addr;
	// read requests as {y, v, u}
	logic [2:0] rd_sel;
	logic [2:0] rd_issue;
	logic [2:0] rd_pipe [`SRAM_LATENCY];
	logic chroma_rd;
	logic wr_now;
	pixel_t r0_q, g0_q, b0_q, r1_q, g1_q, b1_q;
	sram_word_t pack_word;

	assign chroma_rd = !pair_cnt[0] && (pair_cnt < CHROMA_PAIRS);
	// slot k writes pair k-1, so slot 0 stays quiet
	assign wr_now = (phase >= 3'd3) &&
		((state == pair_write && pair_cnt != '0) || state == lead_out);

	always_comb begin
		rd_sel = 3'b000;
		if (state == lead_in) begin
			if (phase < 3'd2)
				rd_sel = 3'b001;
			else if (phase < 3'd4)
				rd_sel = 3'b010;
		end else if (state == pair_read) begin
			case (phase)
				3'd0: rd_sel = 3'b100;
				3'd1: rd_sel = {2'b00, chroma_rd};
				default: rd_sel = {1'b0, chroma_rd, 1'b0};
			endcase
		end
	end

	always_comb begin
		case (phase)
			3'd3: pack_word = {r0_q, g0_q};
			3'd4: pack_word = {b0_q, r1_q};
			default: pack_word = {g1_q, b1_q};
		endcase
	end

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			state <= idle;
			phase <= 3'd0;
			pair_cnt <= '0;
			row_cnt <= '0;
			y_addr <= sram_addr_t'(`Y_BASE);
			u_addr <= sram_addr_t'(`U_BASE);
			v_addr <= sram_addr_t'(`V_BASE);
			rgb_addr <= sram_addr_t'(`RGB_BASE);
			sram_address <= '0;
			sram_we_n <= 1'b1;
			done <= 1'b0;
			rd_issue <= 3'b000;
			row_start <= 1'b0;
			shift <= 1'b0;
			pair_go <= 1'b0;
		end else begin
			sram_we_n <= !wr_now;
			rd_issue <= rd_sel;
			row_start <= (state == lead_in) && (phase == 3'd0);
			pair_go <= (state == pair_write) && (phase == 3'd3);
			shift <= (state == pair_write) && (phase == 3'd5);
			done <= (state == frame_done);

			if (wr_now) begin
				sram_address <= rgb_addr;
				rgb_addr <= rgb_addr + 1'b1;
			end else if (rd_sel[2]) begin
				sram_address <= y_addr;
				y_addr <= y_addr + 1'b1;
			end else if (rd_sel[1]) begin
				sram_address <= v_addr;
				v_addr <= v_addr + 1'b1;
			end else if (rd_sel[0]) begin
				sram_address <= u_addr;
				u_addr <= u_addr + 1'b1;
			end

			if (state != idle && state != frame_done)
				phase <= (phase == 3'd5) ? 3'd0 : phase + 1'b1;

			case (state)
				idle: begin
					if (start) begin
						state <= lead_in;
						pair_cnt <= '0;
						row_cnt <= '0;
						y_addr <= sram_addr_t'(`Y_BASE);
						u_addr <= sram_addr_t'(`U_BASE);
						v_addr <= sram_addr_t'(`V_BASE);
						rgb_addr <= sram_addr_t'(`RGB_BASE);
					end
				end
				lead_in: begin
					if (phase == 3'd5)
						state <= pair_read;
				end
				pair_read: begin
					if (phase == 3'd2)
						state <= pair_write;
				end
				pair_write: begin
					if (phase == 3'd5) begin
						if (pair_cnt == LAST_PAIR) begin
							state <= lead_out;
						end else begin
							pair_cnt <= pair_cnt + 1'b1;
							state <= pair_read;
						end
					end
				end
				lead_out: begin
					// drains the last pair of the row
					if (phase == 3'd5) begin
						pair_cnt <= '0;
						if (row_cnt == LAST_ROW) begin
							state <= frame_done;
						end else begin
							row_cnt <= row_cnt + 1'b1;
							state <= lead_in;
						end
					end
				end
				frame_done: state <= idle;
				default: state <= idle;
			endcase
		end
	end

	// strobes follow the address so they line up with the read data
	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			for (int i = 0; i < `SRAM_LATENCY; i++)
				rd_pipe[i] <= 3'b000;
		end else begin
			rd_pipe[0] <= rd_issue;
			for (int i = 1; i < `SRAM_LATENCY; i++)
				rd_pipe[i] <= rd_pipe[i-1];
		end
	end

	assign chroma_capture = rd_pipe[`SRAM_LATENCY-1][1:0];
	assign y_capture = rd_pipe[`SRAM_LATENCY-1][2];

	always_ff @(posedge CLOCK_50_I) begin
		if (rgb_valid) begin
			r0_q <= r0;
			g0_q <= g0;
			b0_q <= b0;
			r1_q <= r1;
			g1_q <= g1;
			b1_q <= b1;
		end
		if (wr_now)
			sram_write_data <= pack_word;
	end

endmodule

`default_nettype wire

/* logic/yuv_rgb_top.sv */
`timescale 1ns/1ps
`default_nettype none

module yuv_rgb_top import yuv_rgb_pkg::*; (
	input  logic       CLOCK_50_I,
	input  logic       Resetn,
	input  logic       start,
	input  sram_word_t sram_read_data,
	output sram_addr_t sram_address,
	output logic       sram_we_n,
	output sram_word_t sram_write_data,
	output logic       done
);

	// bit 0 strobes U words, bit 1 V words
	logic [1:0] chroma_capture;
	logic row_start;
	logic shift;
	logic y_capture;
	logic pair_go;
	logic rgb_valid;
	pixel_t u_even, v_even;
	chroma_t u_odd, v_odd;
	pixel_t r0, g0, b0, r1, g1, b1;

	sram_sequencer seq_i (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.start(start),
		.sram_address(sram_address),
		.sram_we_n(sram_we_n),
		.sram_write_data(sram_write_data),
		.done(done),
		.chroma_capture(chroma_capture),
		.row_start(row_start),
		.shift(shift),
		.y_capture(y_capture),
		.pair_go(pair_go),
		.rgb_valid(rgb_valid),
		.r0(r0),
		.g0(g0),
		.b0(b0),
		.r1(r1),
		.g1(g1),
		.b1(b1)
	);

	chroma_upsampler u_ups_i (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.read_data(sram_read_data),
		.chroma_capture(chroma_capture[0]),
		.row_start(row_start),
		.shift(shift),
		.even_chroma(u_even),
		.odd_chroma(u_odd)
	);

	chroma_upsampler v_ups_i (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.read_data(sram_read_data),
		.chroma_capture(chroma_capture[1]),
		.row_start(row_start),
		.shift(shift),
		.even_chroma(v_even),
		.odd_chroma(v_odd)
	);

	color_matrix matrix_i (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.y_word(sram_read_data),
		.y_capture(y_capture),
		.pair_go(pair_go),
		.u_even(u_even),
		.v_even(v_even),
		.u_odd(u_odd),
		.v_odd(v_odd),
		.rgb_valid(rgb_valid),
		.r0(r0),
		.g0(g0),
		.b0(b0),
		.r1(r1),
		.g1(g1),
		.b1(b1)
	);

endmodule

`default_nettype wire

/* verification/yuv_rgb_sva.sv */
`timescale 1ns/1ps
`default_nettype none
`include "yuv_rgb_config.svh"

module yuv_rgb_sva import yuv_rgb_pkg::*; (
	input logic       CLOCK_50_I,
	input logic       Resetn,
	input logic       start,
	input sram_addr_t sram_address,
	input logic       sram_we_n,
	input logic       done
);

	localparam int RGB_WORDS = `IMG_WIDTH * `IMG_HEIGHT * 3 / 2;
	localparam sram_addr_t RGB_FIRST = sram_addr_t'(`RGB_BASE);
	localparam sram_addr_t RGB_LAST = sram_addr_t'(`RGB_BASE + RGB_WORDS - 1);

	int fail_count = 0;
	logic started;
	logic wr_seen;
	sram_addr_t last_wr;

	always_ff @(posedge CLOCK_50_I or negedge Resetn) begin
		if (!Resetn) begin
			started <= 1'b0;
			wr_seen <= 1'b0;
			last_wr <= '0;
		end else begin
			if (start)
				started <= 1'b1;
			// a new frame begins again at the RGB base
			if (done) begin
				wr_seen <= 1'b0;
			end else if (!sram_we_n) begin
				wr_seen <= 1'b1;
				last_wr <= sram_address;
			end
		end
	end

	quiet_before_start: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		!started |-> (sram_we_n && !done))
		else begin
			fail_count++;
			$error("write or done seen before the first start");
		end

	write_in_rgb_area: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		!sram_we_n |-> (sram_address >= RGB_FIRST && sram_address <= RGB_LAST))
		else begin
			fail_count++;
			$error("write address %0h outside the RGB area", sram_address);
		end

	write_step: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		!sram_we_n |-> (sram_address == (wr_seen ? last_wr + sram_addr_t'(1) : RGB_FIRST)))
		else begin
			fail_count++;
			$error("write address %0h does not follow the previous write", sram_address);
		end

	done_single_cycle: assert property (@(posedge CLOCK_50_I) disable iff (!Resetn)
		done |=> !done)
		else begin
			fail_count++;
			$error("done stayed high for more than one cycle");
		end

endmodule

bind yuv_rgb_top yuv_rgb_sva sva_i (
	.CLOCK_50_I(CLOCK_50_I),
	.Resetn(Resetn),
	.start(start),
	.sram_address(sram_address),
	.sram_we_n(sram_we_n),
	.done(done)
);

`default_nettype wire

/* verification/tb_yuv_rgb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "yuv_rgb_config.svh"

module tb_yuv_rgb import yuv_rgb_pkg::*; ();

	localparam int PAIRS_PER_ROW = `IMG_WIDTH / 2;
	// chroma words per row and plane
	localparam int CHROMA_WORDS = `IMG_WIDTH / 4;
	localparam int FRAME_PAIRS = PAIRS_PER_ROW * `IMG_HEIGHT;
	localparam int RGB_WORDS = FRAME_PAIRS * 3;
	localparam int MEM_WORDS = `RGB_BASE + RGB_WORDS;
	localparam int FRAME_EST = FRAME_PAIRS * 8 + `IMG_HEIGHT * 24;
	localparam int WATCHDOG_CYCLES = 4 * 2 * FRAME_EST;

	logic CLOCK_50_I = 1'b0;
	logic Resetn;
	logic start;
	sram_word_t sram_read_data = '0;
	sram_addr_t sram_address;
	logic sram_we_n;
	sram_word_t sram_write_data;
	logic done;
	logic wipe_rgb;

	sram_word_t mem [MEM_WORDS];
	sram_word_t image [`RGB_BASE];
	sram_word_t expected [RGB_WORDS];
	sram_word_t first_rgb [RGB_WORDS];
	sram_word_t read_pipe = '0;
	int errors;
	int tests_run;
	int tests_failed;

	always #2 CLOCK_50_I = !CLOCK_50_I;

	yuv_rgb_top dut_i (
		.CLOCK_50_I(CLOCK_50_I),
		.Resetn(Resetn),
		.start(start),
		.sram_read_data(sram_read_data),
		.sram_address(sram_address),
		.sram_we_n(sram_we_n),
		.sram_write_data(sram_write_data),
		.done(done)
	);

	function automatic sram_word_t fill_word(input int a);
		return sram_word_t'(a) ^ 16'ha5a5;
	endfunction

	// sram model, image loaded while in reset, two cycles of read delay
	always @(posedge CLOCK_50_I) begin
		if (!Resetn) begin
			for (int a = 0; a < `RGB_BASE; a++)
				mem[a] <= image[a];
			for (int a = `RGB_BASE; a < MEM_WORDS; a++)
				mem[a] <= fill_word(a);
			read_pipe <= '0;
			sram_read_data <= '0;
		end else begin
			if (wipe_rgb) begin
				for (int a = `RGB_BASE; a < MEM_WORDS; a++)
					mem[a] <= fill_word(a);
			end else if (!sram_we_n && int'(sram_address) < MEM_WORDS) begin
				mem[sram_address] <= sram_write_data;
			end
			read_pipe <= (int'(sram_address) < MEM_WORDS) ? mem[sram_address] : 16'hxxxx;
			sram_read_data <= read_pipe;
		end
	end

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	task automatic make_image();
		logic [31:0] lcg_state;
		lcg_state = 32'h84cab9ff;
		for (int a = 0; a < `RGB_BASE; a++) begin
			lcg_state = lcg_next(lcg_state);
			image[a] = lcg_state[23:8];
		end
		// Y=255 with V=255 in row 0, Y=0 with U=0 in row 1
		image[`Y_BASE][15:8] = 8'hff;
		image[`V_BASE][15:8] = 8'hff;
		image[`Y_BASE + PAIRS_PER_ROW][15:8] = 8'h00;
		image[`U_BASE + CHROMA_WORDS][15:8] = 8'h00;
	endtask

	// chroma sample with the index clamped into the row
	function automatic int chroma_at(input int base, input int row, input int idx);
		int i;
		sram_word_t w;
		i = (idx < 0) ? 0 : ((idx > PAIRS_PER_ROW - 1) ? PAIRS_PER_ROW - 1 : idx);
		w = image[base + row * CHROMA_WORDS + i / 2];
		return (i % 2 == 0) ? int'(w[15:8]) : int'(w[7:0]);
	endfunction

	function automatic int interp_chroma(input int base, input int row, input int k);
		int acc;
		acc = `FIR_C0 * (chroma_at(base, row, k - 2) + chroma_at(base, row, k + 3))
			+ `FIR_C1 * (chroma_at(base, row, k - 1) + chroma_at(base, row, k + 2))
			+ `FIR_C2 * (chroma_at(base, row, k) + chroma_at(base, row, k + 1))
			+ `FIR_ROUND;
		return acc >>> `FIR_SHIFT;
	endfunction

	function automatic pixel_t clip(input int sum);
		int s;
		s = sum >>> `CSC_SHIFT;
		if (s < 0)
			return 8'd0;
		if (s > 255)
			return 8'd255;
		return pixel_t'(s);
	endfunction

	task automatic pixel_rgb(input int y, input int u, input int v,
		output pixel_t r, output pixel_t g, output pixel_t b);
		int ys;
		ys = `CSC_KY * (y - `Y_OFFSET);
		r = clip(ys + `CSC_KRV * (v - `C_OFFSET));
		g = clip(ys + `CSC_KGU * (u - `C_OFFSET) + `CSC_KGV * (v - `C_OFFSET));
		b = clip(ys + `CSC_KBU * (u - `C_OFFSET));
	endtask

	task automatic build_expected();
		sram_word_t yw;
		pixel_t r0, g0, b0, r1, g1, b1;
		int w;
		for (int row = 0; row < `IMG_HEIGHT; row++) begin
			for (int k = 0; k < PAIRS_PER_ROW; k++) begin
				yw = image[`Y_BASE + row * PAIRS_PER_ROW + k];
				pixel_rgb(int'(yw[15:8]), chroma_at(`U_BASE, row, k),
					chroma_at(`V_BASE, row, k), r0, g0, b0);
				pixel_rgb(int'(yw[7:0]), interp_chroma(`U_BASE, row, k),
					interp_chroma(`V_BASE, row, k), r1, g1, b1);
				w = (row * PAIRS_PER_ROW + k) * 3;
				expected[w] = {r0, g0};
				expected[w + 1] = {b0, r1};
				expected[w + 2] = {g1, b1};
			end
		end
	endtask

	task automatic check_value(input string name, input logic [31:0] want,
		input logic [31:0] got);
		assert (want === got) else begin
			$display("[FAIL] %s: expected %0h, actual %0h", name, want, got);
			errors++;
		end
	endtask

	task automatic finish_test(input string name, input int errors_before);
		tests_run++;
		if (errors == errors_before) begin
			$display("test %s: passed", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d checks failed", name, errors - errors_before);
		end
	endtask

	function automatic string where(input int p);
		return $sformatf("row %0d pair %0d", p / PAIRS_PER_ROW, p % PAIRS_PER_ROW);
	endfunction

	task automatic run_frame(output int writes);
		writes = 0;
		@(posedge CLOCK_50_I);
		start <= 1'b1;
		@(posedge CLOCK_50_I);
		start <= 1'b0;
		do begin
			@(negedge CLOCK_50_I);
			if (!sram_we_n)
				writes++;
		end while (!done);
	endtask

	initial begin
		int writes;
		int err0;
		Resetn <= 1'b0;
		start <= 1'b0;
		wipe_rgb <= 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		make_image();
		build_expected();
		repeat (3) @(posedge CLOCK_50_I);
		Resetn <= 1'b1;
		// idle stretch so the reset-state assertion gets exercised
		repeat (8) @(posedge CLOCK_50_I);
		err0 = errors;
		check_value("reset_state assertion failures", 0, dut_i.sva_i.fail_count);
		finish_test("reset_state", err0);

		run_frame(writes);
		err0 = errors;
		for (int p = 0; p < FRAME_PAIRS; p++) begin
			check_value({"even_pixels ", where(p), " R0G0"}, expected[3 * p],
				mem[`RGB_BASE + 3 * p]);
			check_value({"even_pixels ", where(p), " B0"}, expected[3 * p + 1][15:8],
				mem[`RGB_BASE + 3 * p + 1][15:8]);
		end
		finish_test("even_pixels", err0);

		err0 = errors;
		for (int p = 0; p < FRAME_PAIRS; p++) begin
			check_value({"odd_pixels ", where(p), " R1"}, expected[3 * p + 1][7:0],
				mem[`RGB_BASE + 3 * p + 1][7:0]);
			check_value({"odd_pixels ", where(p), " G1B1"}, expected[3 * p + 2],
				mem[`RGB_BASE + 3 * p + 2]);
		end
		finish_test("odd_pixels", err0);

		err0 = errors;
		check_value("saturation row 0 R0", 8'd255, mem[`RGB_BASE][15:8]);
		check_value("saturation row 1 B0", 8'd0, mem[`RGB_BASE + PAIRS_PER_ROW * 3 + 1][15:8]);
		finish_test("saturation", err0);

		err0 = errors;
		check_value("write_region write count", RGB_WORDS, writes);
		for (int a = 0; a < `RGB_BASE; a++)
			check_value($sformatf("write_region input word %0d", a), image[a], mem[a]);
		check_value("write_region assertion failures", 0, dut_i.sva_i.fail_count);
		finish_test("write_region", err0);

		err0 = errors;
		for (int i = 0; i < RGB_WORDS; i++)
			first_rgb[i] = mem[`RGB_BASE + i];
		@(posedge CLOCK_50_I);
		wipe_rgb <= 1'b1;
		@(posedge CLOCK_50_I);
		wipe_rgb <= 1'b0;
		run_frame(writes);
		check_value("restart write count", RGB_WORDS, writes);
		for (int i = 0; i < RGB_WORDS; i++)
			check_value($sformatf("restart word %0d", i), first_rgb[i], mem[`RGB_BASE + i]);
		check_value("restart assertion failures", 0, dut_i.sva_i.fail_count);
		finish_test("restart", err0);

		$display("summary: %0d tests, %0d failed, %0d failed checks",
			tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0) begin
			$display("STATUS: PASS");
		end else begin
			$display("STATUS: FAIL");
		end
		$finish;
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge CLOCK_50_I);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

`default_nettype wire

/* flist.f */
+incdir+logic
logic/yuv_rgb_pkg.sv
logic/chroma_upsampler.sv
logic/color_matrix.sv
logic/sram_sequencer.sv
logic/yuv_rgb_top.sv
verification/yuv_rgb_sva.sv
verification/tb_yuv_rgb.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_yuv_rgb
FLIST ?= flist.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -Wno-fatal
RUN_ARGS ?= +verilator+error+limit+1000
PASS_TEXT ?= STATUS: PASS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
